// ==== logic/alu.sv ====
// ALU control decode and the ALU datapath with zero and overflow flags
`timescale 1ns/1ns
`default_nettype none

module alu import ex_pkg::*; (
	input  alu_op_t   alu_op,
	input  wire [5:0] fnc_code,
	input  word_t     op_1,
	input  word_t     op_2,
	output word_t     res,
	output logic      zero,
	output logic      over,
	output logic      bad
);

	// --------------------
	// Control decode
	alu_ctrl_t alu_ctrl;

	always_comb
	begin
		case (alu_op)
			AOP_ADD: alu_ctrl = ALU_ADD;
			AOP_SUB: alu_ctrl = ALU_SUB;
			AOP_AND: alu_ctrl = ALU_AND;
			default:
			begin
				case (fnc_code) // R-type
					FN_SRA:  alu_ctrl = ALU_SRA;
					FN_MUL:  alu_ctrl = ALU_MUL;
					FN_DIV:  alu_ctrl = ALU_DIV;
					FN_ADD:  alu_ctrl = ALU_ADD;
					FN_ADDU: alu_ctrl = ALU_ADD; // Same datapath, no flag
					FN_SUB:  alu_ctrl = ALU_SUB;
					FN_AND:  alu_ctrl = ALU_AND;
					FN_OR:   alu_ctrl = ALU_OR;
					FN_XOR:  alu_ctrl = ALU_XOR;
					FN_NOR:  alu_ctrl = ALU_NOR;
					FN_SLT:  alu_ctrl = ALU_SLT;
					default: alu_ctrl = ALU_BAD;
				endcase
			end
		endcase
	end

	assign bad = (alu_ctrl == ALU_BAD);

	// --------------------
	// Datapath
	logic [32:0] sum_ext; // Carry out in bit 32

	assign sum_ext = {1'b0, op_1} + {1'b0, op_2};

	always_comb
	begin
		case (alu_ctrl)
			ALU_ADD: res = sum_ext[31:0];
			ALU_SUB: res = op_1 - op_2;
			ALU_AND: res = op_1 & op_2;
			ALU_OR:  res = op_1 | op_2;
			ALU_XOR: res = op_1 ^ op_2;
			ALU_NOR: res = ~(op_1 | op_2);
			ALU_SLT: res = (op_1 < op_2) ? 32'd1 : 32'd0; // Unsigned compare
			ALU_MUL: res = op_1 * op_2;                   // Low half only
			ALU_DIV: res = (op_2 == '0) ? '1 : op_1 / op_2;
			ALU_SRA: res = $signed(op_2) >>> op_1[4:0];
			default: res = '0;
		endcase
	end

	// --------------------
	// Flags
	logic is_rtype;

	assign is_rtype = (alu_op == AOP_RTYPE); // ADDI low bits must not alias FN_ADD

	// Unsigned carry for ADD, borrow for SUB
	assign over = is_rtype &
		(((fnc_code == FN_ADD) & sum_ext[32]) | ((fnc_code == FN_SUB) & (op_1 < op_2)));

	assign zero = (res == '0);

endmodule

`default_nettype wire

// ==== logic/ex_pipe_top.sv ====
// Top level joining operand fetch, execute, writeback and the register file
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_top import ex_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       instr_valid,
	input  word_t     instr,
	input  wire       flush,
	output logic      wb_valid,
	output reg_addr_t wb_dest,
	output word_t     wb_data,
	output logic      wb_write,
	output logic      wb_over
);

	reg_addr_t rd_addr_1;
	reg_addr_t rd_addr_2;
	word_t     rd_data_1;
	word_t     rd_data_2;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;

	// --------------------
	// Stages
	operand_fetch u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_addr_1   (rd_addr_1),
		.rd_addr_2   (rd_addr_2),
		.rd_data_1   (rd_data_1),
		.rd_data_2   (rd_data_2),
		.id_ex       (id_ex)
	);

	register_file u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_1 (rd_addr_1),
		.rd_addr_2 (rd_addr_2),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2),
		.wr_en     (wb_write), // Commit from writeback
		.wr_addr   (wb_dest),
		.wr_data   (wb_data)
	);

	execute_stage u_exec (
		.clk      (clk),
		.rst_n    (rst_n),
		.id_ex    (id_ex),
		.flush    (flush),
		.wb_write (wb_write), // Second forwarding source
		.wb_dest  (wb_dest),
		.wb_data  (wb_data),
		.ex_mem   (ex_mem)
	);

	writeback_stage u_wb (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem   (ex_mem),
		.wb_valid (wb_valid),
		.wb_dest  (wb_dest),
		.wb_data  (wb_data),
		.wb_write (wb_write),
		.wb_over  (wb_over)
	);

endmodule

`default_nettype wire

// ==== logic/ex_pkg.sv ====
// Shared typedefs, ALU codes, opcode and function constants, pipeline structs
`default_nettype none

package ex_pkg;

	// --------------------
	// Basic types
	typedef logic [31:0] word_t;     // Data word
	typedef logic [4:0]  reg_addr_t; // Register number
	typedef logic [3:0]  alu_ctrl_t; // Fine ALU operation
	typedef logic [1:0]  alu_op_t;   // Coarse class from decode
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  fnc_t;

	// --------------------
	// ALU operation codes
	localparam alu_ctrl_t ALU_ADD = 4'd0;
	localparam alu_ctrl_t ALU_SUB = 4'd1;
	localparam alu_ctrl_t ALU_AND = 4'd2;
	localparam alu_ctrl_t ALU_OR  = 4'd3;
	localparam alu_ctrl_t ALU_XOR = 4'd4;
	localparam alu_ctrl_t ALU_NOR = 4'd5;
	localparam alu_ctrl_t ALU_SLT = 4'd6;
	localparam alu_ctrl_t ALU_MUL = 4'd7;
	localparam alu_ctrl_t ALU_DIV = 4'd8;
	localparam alu_ctrl_t ALU_SRA = 4'd9;
	localparam alu_ctrl_t ALU_BAD = 4'hf; // Unknown function code

	// Coarse classes, as produced by decode
	localparam alu_op_t AOP_ADD   = 2'd0;
	localparam alu_op_t AOP_SUB   = 2'd1;
	localparam alu_op_t AOP_RTYPE = 2'd2; // Function code decides
	localparam alu_op_t AOP_AND   = 2'd3;

	// --------------------
	// Opcodes and R-type function codes
	localparam opcode_t OP_RTYPE = 6'd0;
	localparam opcode_t OP_ADDI  = 6'd8;
	localparam opcode_t OP_ANDI  = 6'd12;

	localparam fnc_t FN_SRA  = 6'd3;
	localparam fnc_t FN_MUL  = 6'd24;
	localparam fnc_t FN_DIV  = 6'd26;
	localparam fnc_t FN_ADD  = 6'd32;
	localparam fnc_t FN_ADDU = 6'd33;
	localparam fnc_t FN_SUB  = 6'd34;
	localparam fnc_t FN_AND  = 6'd36;
	localparam fnc_t FN_OR   = 6'd37;
	localparam fnc_t FN_XOR  = 6'd38;
	localparam fnc_t FN_NOR  = 6'd39;
	localparam fnc_t FN_SLT  = 6'd42;

	// --------------------
	// Pipeline registers
	typedef struct packed {
		logic      valid;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t     data_1;    // Register read of rs
		word_t     data_2;    // Register read of rt
		word_t     imm;       // Sign-extended, low 6 bits are the function code
		alu_op_t   alu_op;
		logic      alu_src;   // Immediate replaces operand B
		logic      reg_dst;   // Write rd instead of rt
		logic      reg_write;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     res;
		logic      reg_write;
		logic      zero;
		logic      over;      // Overflow, blocks the commit
	} ex_mem_t;

endpackage

`default_nettype wire

// ==== logic/execute_stage.sv ====
// Forwarding unit, operand muxes, flush and the EX/MEM register
`timescale 1ns/1ns
`default_nettype none

module execute_stage import ex_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  id_ex_t    id_ex,
	input  wire       flush,
	input  wire       wb_write,
	input  reg_addr_t wb_dest,
	input  word_t     wb_data,
	output ex_mem_t   ex_mem
);

	// --------------------
	// Forwarding
	logic mem_hit_a; // EX/MEM holds newer rs
	logic mem_hit_b; // EX/MEM holds newer rt
	logic wb_hit_a;
	logic wb_hit_b;
	logic mem_fwd_ok;

	// An overflowing entry never commits, so it is no source either
	assign mem_fwd_ok = ex_mem.valid & ex_mem.reg_write & ~ex_mem.over & (ex_mem.dest != '0);

	assign mem_hit_a = mem_fwd_ok & (ex_mem.dest == id_ex.rs);
	assign mem_hit_b = mem_fwd_ok & (ex_mem.dest == id_ex.rt);
	assign wb_hit_a  = wb_write & (wb_dest == id_ex.rs); // wb_write excludes r0
	assign wb_hit_b  = wb_write & (wb_dest == id_ex.rt);

	word_t op_1;
	word_t fwd_b; // Register operand B after forwarding
	word_t op_2;

	always_comb
	begin
		if (mem_hit_a)
			op_1 = ex_mem.res;   // Distance 1
		else if (wb_hit_a)
			op_1 = wb_data;      // Distance 2
		else
			op_1 = id_ex.data_1;

		if (mem_hit_b)
			fwd_b = ex_mem.res;
		else if (wb_hit_b)
			fwd_b = wb_data;
		else
			fwd_b = id_ex.data_2;
	end

	assign op_2 = id_ex.alu_src ? id_ex.imm : fwd_b; // Immediate for ADDI and ANDI

	// --------------------
	// ALU
	word_t alu_res;
	logic  alu_zero;
	logic  alu_over;
	logic  alu_bad;

	alu u_alu (
		.alu_op   (id_ex.alu_op),
		.fnc_code (id_ex.imm[5:0]), // Function field of R-type
		.op_1     (op_1),
		.op_2     (op_2),
		.res      (alu_res),
		.zero     (alu_zero),
		.over     (alu_over),
		.bad      (alu_bad)
	);

	// --------------------
	// EX/MEM register
	ex_mem_t ex_mem_d;
	logic    kill; // Cancelled or undecodable

	assign kill = flush | alu_bad;

	always_comb
	begin
		ex_mem_d.valid     = id_ex.valid & ~kill;
		ex_mem_d.dest      = id_ex.reg_dst ? id_ex.rd : id_ex.rt;
		ex_mem_d.res       = alu_res;
		ex_mem_d.reg_write = id_ex.reg_write & ~kill;
		ex_mem_d.zero      = alu_zero;
		ex_mem_d.over      = alu_over;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_mem <= '0;
		else
			ex_mem <= ex_mem_d;
	end

	// Flushed instruction leaves as a bubble
	a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !ex_mem.valid);

endmodule

`default_nettype wire

// ==== logic/operand_fetch.sv ====
// Instruction decode, register read and the ID/EX register
`timescale 1ns/1ns
`default_nettype none

module operand_fetch import ex_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       instr_valid,
	input  word_t     instr,
	output reg_addr_t rd_addr_1,
	output reg_addr_t rd_addr_2,
	input  word_t     rd_data_1,
	input  word_t     rd_data_2,
	output id_ex_t    id_ex
);

	// --------------------
	// Field split
	opcode_t   opcode;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = {{16{instr[15]}}, instr[15:0]}; // Sign-extended

	assign rd_addr_1 = rs; // Register file sees the raw fields
	assign rd_addr_2 = rt;

	// --------------------
	// Opcode decode
	logic    known;      // Opcode is one we execute
	alu_op_t alu_op;
	logic    alu_src;
	logic    reg_dst;
	logic    reg_write;

	always_comb
	begin
		known     = 1'b1;
		alu_op    = AOP_ADD;
		alu_src   = 1'b0;
		reg_dst   = 1'b0;
		reg_write = 1'b1;
		case (opcode)
			OP_RTYPE:
			begin
				alu_op  = AOP_RTYPE; // Function code picks the op
				reg_dst = 1'b1;      // Result into rd
			end
			OP_ADDI:
			begin
				alu_op  = AOP_ADD;
				alu_src = 1'b1;
			end
			OP_ANDI:
			begin
				alu_op  = AOP_AND;
				alu_src = 1'b1;
			end
			default:
			begin
				known     = 1'b0; // Travels as a bubble
				reg_write = 1'b0;
			end
		endcase
	end

	// --------------------
	// ID/EX register
	id_ex_t id_ex_d;

	always_comb
	begin
		id_ex_d.valid     = instr_valid & known;
		id_ex_d.rs        = rs;
		id_ex_d.rt        = rt;
		id_ex_d.rd        = rd;
		id_ex_d.data_1    = rd_data_1;
		id_ex_d.data_2    = rd_data_2;
		id_ex_d.imm       = imm;
		id_ex_d.alu_op    = alu_op;
		id_ex_d.alu_src   = alu_src;
		id_ex_d.reg_dst   = reg_dst;
		id_ex_d.reg_write = instr_valid & reg_write; // Idle cycles write nothing
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			id_ex <= '0;
		else
			id_ex <= id_ex_d;
	end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
// 32x32 register file with hardwired zero register and write-through reads
`timescale 1ns/1ns
`default_nettype none

module register_file import ex_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  reg_addr_t rd_addr_1,
	input  reg_addr_t rd_addr_2,
	output word_t     rd_data_1,
	output word_t     rd_data_2,
	input  wire       wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [1:31]; // No storage behind register 0

	// Write port, register 0 never stored
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
			regs[wr_addr] <= wr_data;
	end

	// Reads see the word being written this cycle
	always_comb
	begin
		rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];
		rd_data_2 = (rd_addr_2 == '0) ? '0 : regs[rd_addr_2];
		if (wr_en && (wr_addr != '0) && (wr_addr == rd_addr_1))
			rd_data_1 = wr_data; // Bypass port 1
		if (wr_en && (wr_addr != '0) && (wr_addr == rd_addr_2))
			rd_data_2 = wr_data; // Bypass port 2
	end

	// Writeback must already have filtered register 0
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_addr != '0));

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
// MEM/WB register, write-enable qualification and the result ports
`timescale 1ns/1ns
`default_nettype none

module writeback_stage import ex_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  ex_mem_t   ex_mem,
	output logic      wb_valid,
	output reg_addr_t wb_dest,
	output word_t     wb_data,
	output logic      wb_write,
	output logic      wb_over
);

	ex_mem_t mem_wb; // MEM/WB register

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_wb <= '0;
		else
			mem_wb <= ex_mem;
	end

	assign wb_valid = mem_wb.valid;
	assign wb_dest  = mem_wb.dest;
	assign wb_data  = mem_wb.res;
	assign wb_over  = mem_wb.valid & mem_wb.over; // Reported, never committed

	// Commit only a clean write to a real register
	assign wb_write = mem_wb.valid & mem_wb.reg_write & ~mem_wb.over & (mem_wb.dest != '0);

	a_write_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wb_write |-> wb_valid);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module ex_pipe_tb -o ex_pipe_sim

./obj_dir/ex_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi

// ==== src.f ====
logic/ex_pkg.sv
logic/register_file.sv
logic/operand_fetch.sv
logic/alu.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/ex_pipe_top.sv
verif/tb_clock.sv
verif/ex_pipe_tb.sv

// ==== verif/ex_pipe_tb.sv ====
// Pipeline testbench with stimulus, reference model, assertions, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_tb import ex_pkg::*; ();

	localparam int PERIOD_NS      = 40;
	localparam int N_RANDOM       = 300;
	localparam int DIRECTED_SLOTS = 70;                          // Upper bound incl. drain
	localparam int SLOT_BOUND     = DIRECTED_SLOTS + 2 * N_RANDOM; // Random gaps at most double

	// Expected writeback entry
	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     data;
		logic      write;
		logic      over;
	} wb_exp_t;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	word_t     instr;
	logic      flush;
	logic      wb_valid;
	reg_addr_t wb_dest;
	word_t     wb_data;
	logic      wb_write;
	logic      wb_over;

	integer  seed;
	int      errors;
	int      issued;
	logic    flush_pending; // Flush due on the next slot
	word_t   model_regs [0:31];
	wb_exp_t issue_exp;     // Entry of the slot being driven
	wb_exp_t exp_pipe [0:2];
	wb_exp_t due;           // Entry that writeback shows now

	fnc_t fn_list [0:11] = '{FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_XOR,
		FN_NOR, FN_SLT, FN_MUL, FN_DIV, FN_SRA, 6'd63}; // Last one unknown

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst_n(rst_n));

	ex_pipe_top dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_dest     (wb_dest),
		.wb_data     (wb_data),
		.wb_write    (wb_write),
		.wb_over     (wb_over)
	);

	// --------------------
	// Reference model
	function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, fnc_t fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wb_exp_t predict(word_t ins);
		wb_exp_t     e;
		word_t       a;
		word_t       b;
		word_t       simm;
		logic [32:0] wide;
		logic        ok;
		e    = '0;
		ok   = 1'b1;
		a    = model_regs[ins[25:21]]; // rs
		b    = model_regs[ins[20:16]]; // rt
		simm = {{16{ins[15]}}, ins[15:0]};
		if (ins[31:26] == OP_ADDI)
		begin
			e.dest = ins[20:16];
			e.data = a + simm; // No flag for ADDI
		end
		else if (ins[31:26] == OP_ANDI)
		begin
			e.dest = ins[20:16];
			e.data = a & simm;
		end
		else if (ins[31:26] == OP_RTYPE)
		begin
			e.dest = ins[15:11];
			case (ins[5:0])
				FN_ADD:
				begin
					wide   = {1'b0, a} + {1'b0, b};
					e.data = wide[31:0];
					e.over = wide[32]; // Carry out
				end
				FN_ADDU: e.data = a + b;
				FN_SUB:
				begin
					e.data = a - b;
					e.over = (a < b); // Borrow
				end
				FN_AND:  e.data = a & b;
				FN_OR:   e.data = a | b;
				FN_XOR:  e.data = a ^ b;
				FN_NOR:  e.data = ~(a | b);
				FN_SLT:  e.data = (a < b) ? 32'd1 : 32'd0;
				FN_MUL:  e.data = a * b;
				FN_DIV:  e.data = (b == '0) ? '1 : a / b;
				FN_SRA:  e.data = $signed(b) >>> a[4:0];
				default: ok = 1'b0;
			endcase
		end
		else
			ok = 1'b0;
		e.valid = 1'b1;
		e.write = (e.dest != '0) & ~e.over;
		if (!ok)
			e = '0; // Bubble
		return e;
	endfunction

	// --------------------
	// Stimulus slots, one per falling edge
	task automatic issue_slot(input logic v, input word_t ins, input logic kill);
		wb_exp_t e;
		@(negedge clk);
		flush         = flush_pending; // Cancels what sits in ID/EX
		flush_pending = v & kill;
		instr_valid   = v;
		instr         = ins;
		e             = '0;
		if (v)
			issued++;
		if (v && !kill)
		begin
			e = predict(ins);
			if (e.write)
				model_regs[e.dest] = e.data;
		end
		issue_exp = e;
	endtask

	task automatic issue(input word_t ins);
		issue_slot(1'b1, ins, 1'b0);
	endtask

	task automatic issue_flushed(input word_t ins);
		issue_slot(1'b1, ins, 1'b1);
	endtask

	task automatic bubble();
		issue_slot(1'b0, word_t'($random(seed)), 1'b0); // Garbage must be ignored
	endtask

	// Expected entries follow the pipeline
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			exp_pipe[0] <= '0;
			exp_pipe[1] <= '0;
			exp_pipe[2] <= '0;
		end
		else
		begin
			exp_pipe[0] <= issue_exp;
			exp_pipe[1] <= exp_pipe[0];
			exp_pipe[2] <= exp_pipe[1];
		end
	end

	assign due = exp_pipe[2];

	// --------------------
	// Checks
	a_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == due.valid)
		else
		begin
			errors++;
			$display("CHECK FAILED wb_valid: got %h, expected %h", $sampled(wb_valid),
				$sampled(due.valid));
		end

	a_write: assert property (@(posedge clk) disable iff (!rst_n) wb_write == due.write)
		else
		begin
			errors++;
			$display("CHECK FAILED wb_write: got %h, expected %h", $sampled(wb_write),
				$sampled(due.write));
		end

	a_over: assert property (@(posedge clk) disable iff (!rst_n) wb_over == due.over)
		else
		begin
			errors++;
			$display("CHECK FAILED wb_over: got %h, expected %h", $sampled(wb_over),
				$sampled(due.over));
		end

	a_dest: assert property (@(posedge clk) disable iff (!rst_n)
		due.valid |-> wb_dest == due.dest)
		else
		begin
			errors++;
			$display("CHECK FAILED wb_dest: got %h, expected %h", $sampled(wb_dest),
				$sampled(due.dest));
		end

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		due.valid |-> wb_data == due.data)
		else
		begin
			errors++;
			$display("CHECK FAILED wb_data: got %h, expected %h", $sampled(wb_data),
				$sampled(due.data));
		end

	// --------------------
	// Watchdog
	initial
	begin
		#((SLOT_BOUND + 10) * PERIOD_NS);
		$display("Watchdog expired before the stimulus finished");
		$display("test failed");
		$finish;
	end

	// --------------------
	// Main sequence
	initial
	begin
		logic [31:0] r;
		logic [3:0]  k;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		word_t       ins;
		seed          = 32'hffbc_7ff8;
		errors        = 0;
		issued        = 0;
		instr_valid   = 1'b0;
		instr         = '0;
		flush         = 1'b0;
		flush_pending = 1'b0;
		issue_exp     = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		wait (rst_n === 1'b1);
		repeat (2) bubble(); // Outputs stay quiet after reset

		// Operands, then every function code on two pairs
		issue(enc_i(OP_ADDI, 5'd0, 5'd1, 16'h1234));
		issue(enc_i(OP_ADDI, 5'd0, 5'd2, 16'hfff0)); // Negative immediate
		issue(enc_i(OP_ADDI, 5'd0, 5'd3, 16'h0003));
		for (int i = 0; i < 12; i++)
		begin
			issue(enc_r(5'd1, 5'd2, 5'd5, fn_list[i])); // ADD carries, SUB borrows
			issue(enc_r(5'd3, 5'd1, 5'd6, fn_list[i]));
		end
		issue(enc_r(5'd1, 5'd0, 5'd7, FN_DIV));       // Divide by zero
		issue(enc_i(6'd2, 5'd1, 5'd8, 16'h0001));      // Unknown opcode
		issue(enc_i(OP_ANDI, 5'd2, 5'd9, 16'h0ff0));

		// Hazard distances 1 to 4
		for (int d = 1; d <= 4; d++)
		begin
			issue(enc_i(OP_ADDI, 5'd10, 5'd10, 16'h0007));
			for (int g = 1; g < d; g++)
				bubble();
			issue(enc_r(5'd10, 5'd10, 5'd11, FN_ADD));
		end

		// Flush, old value must survive
		issue(enc_i(OP_ADDI, 5'd0, 5'd12, 16'h0055));
		issue_flushed(enc_i(OP_ADDI, 5'd0, 5'd12, 16'h00aa));
		issue(enc_r(5'd12, 5'd12, 5'd13, FN_ADD));
		repeat (2) bubble();
		issue(enc_r(5'd12, 5'd0, 5'd13, FN_OR));

		// Register 0 target
		issue(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h0005));
		issue(enc_r(5'd0, 5'd0, 5'd14, FN_ADDU));

		// Overflow leaves the destination alone
		issue(enc_i(OP_ADDI, 5'd0, 5'd15, 16'h0077));
		issue(enc_r(5'd2, 5'd2, 5'd15, FN_ADD));
		issue(enc_r(5'd3, 5'd1, 5'd15, FN_SUB));
		issue(enc_r(5'd15, 5'd0, 5'd16, FN_ADD));

		// Random mix over r0..r3
		for (int n = 0; n < N_RANDOM; n++)
		begin
			r  = $random(seed);
			k  = 4'($unsigned($random(seed)) % 12);
			rs = reg_addr_t'(r[1:0]);
			rt = reg_addr_t'(r[3:2]);
			rd = reg_addr_t'(r[5:4]);
			case (r[8:6])
				3'd0, 3'd1: ins = enc_i(OP_ADDI, rs, rt, r[31:16]);
				3'd2:       ins = enc_i(OP_ANDI, rs, rt, r[31:16]);
				3'd3:       ins = enc_i(6'd5, rs, rt, r[31:16]); // Bubble
				default:    ins = enc_r(rs, rt, rd, fn_list[k]);
			endcase
			if (r[11:9] == 3'd0)
				bubble(); // Stretches the hazard distance
			issue_slot(1'b1, ins, r[14:12] == 3'd0);
		end

		repeat (4) bubble(); // Drain
		@(posedge clk);
		@(negedge clk);
		$display("Issued %0d instructions, %0d errors", issued, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk; // 50 % duty
	end

	initial
	begin
		rst_n = 1'b0;
		#(PERIOD_NS * RESET_CYCLES) rst_n = 1'b1; // Released on a falling edge
	end

endmodule

`default_nettype wire
